//--- list.f
flash_load_pkg.sv
auto_load_fsm.sv
auto_load_const.sv
flash_cmd_ctrl.sv
const_regfile.sv
apb_load_regs.sv
const_loader_top.sv
const_loader_checker.sv
tb_const_loader.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_const_loader -f list.f -o tb_const_loader
if ./obj_dir/tb_const_loader | tee /dev/stderr | grep -F ">>> PASS" > /dev/null; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_const_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_const_loader import flash_load_pkg::*;;

  localparam logic [FLASH_AW-1:0] BASE_ADDR      = 23'h7FC000;
  localparam int                  NUM_CONST      = 34;
  localparam int                  ACCESS_CYCLES  = 3;
  localparam int                  TIMEOUT_CYCLES = 64;

  localparam logic [31:0] LFSR_SEED   = 32'hb19c_9dea;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
  localparam int          APB_TIMEOUT = 16;
  localparam int          POLL_LIMIT  = 500;

  logic                CLK;
  logic                addr_rst    = 1'b1;
  logic                psel        = 1'b0;
  logic                penable     = 1'b0;
  logic                pwrite      = 1'b0;
  logic [11:0]         paddr       = '0;
  logic [31:0]         pwdata      = '0;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic [FLASH_AW-1:0] flash_addr;
  logic [FLASH_DW-1:0] flash_wdata;
  logic                flash_ce_n;
  logic                flash_we_n;
  logic                flash_oe_n;
  logic [FLASH_DW-1:0] flash_rdata = '1;
  logic                flash_ready = 1'b1;
  logic                load_ena;

  int errors    = 0;
  int checks    = 0;
  int apb_waits = 0;

  const_loader_top #(
    .BASE_ADDR      (BASE_ADDR),
    .NUM_CONST      (NUM_CONST),
    .ACCESS_CYCLES  (ACCESS_CYCLES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_const_loader_top (
    .CLK         (CLK),
    .addr_rst    (addr_rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .flash_addr  (flash_addr),
    .flash_wdata (flash_wdata),
    .flash_ce_n  (flash_ce_n),
    .flash_we_n  (flash_we_n),
    .flash_oe_n  (flash_oe_n),
    .flash_rdata (flash_rdata),
    .flash_ready (flash_ready),
    .load_ena    (load_ena)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Behavioral flash
  ////////////////////////////////////////////////////////////
  logic [FLASH_DW-1:0] flash_mem [64];
  logic [FLASH_AW-1:0] cmd_addrs [$];
  logic                we_n_q    = 1'b1;
  logic                ready_low = 1'b0;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // Random data inside the parameter block and an address pattern elsewhere
  function automatic logic [FLASH_DW-1:0] flash_word(input logic [FLASH_AW-1:0] a);
    if (a[FLASH_AW-1:OFFS_W] == BASE_ADDR[FLASH_AW-1:OFFS_W]) begin
      return flash_mem[a[OFFS_W-1:0]];
    end
    return a[15:0] ^ {9'd0, a[22:16]};
  endfunction

  task automatic fill_flash();
    logic [31:0] s;
    s = LFSR_SEED;
    for (int a = 0; a < 64; a++) begin
      for (int b = 0; b < FLASH_DW; b++) begin
        flash_mem[a][b] = s[0];
        s = lfsr_step(s);
      end
    end
  endtask

  always @(posedge CLK) begin
    flash_ready <= !ready_low;
    flash_rdata <= flash_oe_n ? 16'hFFFF : flash_word(flash_addr);
    we_n_q      <= flash_we_n;
    // Falling WE marks a new command cycle
    if (we_n_q && !flash_we_n) begin
      cmd_addrs.push_back(flash_addr);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////////////////////////
  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("%-16s %s", name, (errors == errs_before) ? "ok" : "errors");
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge CLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    while (!pready && n < APB_TIMEOUT) begin
      n++;
      @(posedge CLK);
    end
    if (!pready) begin
      errors++;
      $display("APB transfer to %h never saw pready", addr);
    end
    apb_waits = n;
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic start_load();
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, REG_CTRL, 32'd1, rd, err);
    compare("start_slverr", 0, err);
  endtask

  // Poll status until the load completes or aborts
  task automatic wait_load_end(output logic [31:0] st);
    int   n;
    logic err;
    logic ended;
    n     = 0;
    ended = 1'b0;
    st    = '0;
    while (!ended && n < POLL_LIMIT) begin
      apb_access(1'b0, REG_STATUS, 32'd0, st, err);
      ended = st[ST_COMPLETED] || st[ST_ABORTED];
      n++;
    end
    if (!ended) begin
      errors++;
      $display("Load did not end within %0d status polls", POLL_LIMIT);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic reset_state();
    int          e0;
    logic [31:0] st;
    logic        err;
    e0 = errors;
    apb_access(1'b0, REG_STATUS, 32'd0, st, err);
    compare("reset_status", 0, st);
    compare("reset_status_wait", 0, apb_waits);
    compare("reset_load_ena", 0, load_ena);
    compare("reset_strobes", 3'b111, {flash_ce_n, flash_we_n, flash_oe_n});
    end_test("reset_state", e0);
  endtask

  task automatic full_load();
    int          e0;
    logic [31:0] st;
    e0 = errors;
    cmd_addrs.delete();
    start_load();
    wait_load_end(st);
    compare("load_completed", 1, st[ST_COMPLETED]);
    compare("load_aborted", 0, st[ST_ABORTED]);
    compare("load_stored", 1, st[ST_STORED]);
    compare("load_al_cnt", NUM_CONST - 1, st[13:8]);
    compare("load_ena_status", 0, st[16]);
    compare("load_ena_port", 0, load_ena);
    end_test("full_load", e0);
  endtask

  task automatic const_window();
    int          e0;
    logic [31:0] rd;
    logic        err;
    e0 = errors;
    for (int i = 0; i < NUM_CONST; i++) begin
      apb_access(1'b0, REG_CONST_BASE + 12'(4 * i), 32'd0, rd, err);
      compare($sformatf("const[%0d]", i), flash_word(BASE_ADDR + FLASH_AW'(i)), rd);
      compare($sformatf("const_slverr[%0d]", i), 0, err);
      compare($sformatf("const_wait[%0d]", i), 1, apb_waits);
    end
    end_test("const_window", e0);
  endtask

  task automatic cmd_addr_order();
    int e0;
    e0 = errors;
    compare("cmd_count", NUM_CONST, cmd_addrs.size());
    for (int i = 0; i < NUM_CONST && i < cmd_addrs.size(); i++) begin
      compare($sformatf("cmd_addr[%0d]", i), BASE_ADDR + FLASH_AW'(i), cmd_addrs[i]);
    end
    end_test("cmd_addrs", e0);
  endtask

  task automatic ready_timeout();
    int          e0;
    logic [31:0] st;
    e0 = errors;
    @(posedge CLK);
    ready_low <= 1'b1;
    start_load();
    wait_load_end(st);
    compare("stall_aborted", 1, st[ST_ABORTED]);
    compare("stall_completed", 0, st[ST_COMPLETED]);
    compare("stall_stored", 0, st[ST_STORED]);
    compare("stall_al_cnt", 0, st[13:8]);
    compare("stall_load_ena", 0, load_ena);
    compare("stall_strobes", 3'b111, {flash_ce_n, flash_we_n, flash_oe_n});
    // Flash answers again so the reload goes through
    @(posedge CLK);
    ready_low <= 1'b0;
    start_load();
    wait_load_end(st);
    compare("reload_completed", 1, st[ST_COMPLETED]);
    compare("reload_aborted", 0, st[ST_ABORTED]);
    compare("reload_stored", 1, st[ST_STORED]);
    compare("reload_al_cnt", NUM_CONST - 1, st[13:8]);
    end_test("ready_timeout", e0);
  endtask

  task automatic window_error();
    int          e0;
    logic [31:0] rd;
    logic        err;
    e0 = errors;
    apb_access(1'b0, REG_CONST_BASE + 12'(4 * NUM_CONST), 32'd0, rd, err);
    compare("window_slverr", 1, err);
    end_test("window_error", e0);
  endtask

  initial begin
    fill_flash();
    repeat (5) @(posedge CLK);
    addr_rst <= 1'b0;
    reset_state();
    full_load();
    const_window();
    cmd_addr_order();
    ready_timeout();
    window_error();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- const_loader_checker.sv
`timescale 1ns/1ps
`default_nettype none

module const_loader_checker import flash_load_pkg::*; (
  input  logic                CLK,
  input  logic                addr_rst,
  input  logic                flash_we_n,
  input  logic                flash_oe_n,
  input  logic [FLASH_DW-1:0] flash_wdata,
  input  logic                load_ena,
  input  logic [ST_W-1:0]     al_status
);

  // Only the Read Array command is ever written to the flash
  wdata_is_cmd: assert property (@(posedge CLK) disable iff (addr_rst)
    !flash_we_n |-> (flash_wdata == READ_ARRAY_CMD))
    else $error("write strobe carries %h instead of the Read Array command", flash_wdata);

  we_oe_exclusive: assert property (@(posedge CLK) disable iff (addr_rst)
    !(!flash_we_n && !flash_oe_n))
    else $error("write and output-enable strobes low together");

  // Completed status only once the load has stopped
  ena_vs_completed: assert property (@(posedge CLK) disable iff (addr_rst)
    !(load_ena && al_status[ST_COMPLETED]))
    else $error("load_ena high while the completed status bit is set");

endmodule

bind const_loader_top const_loader_checker u_const_loader_checker (
  .CLK         (CLK),
  .addr_rst    (addr_rst),
  .flash_we_n  (flash_we_n),
  .flash_oe_n  (flash_oe_n),
  .flash_wdata (flash_wdata),
  .load_ena    (load_ena),
  .al_status   (al_status)
);

`default_nettype wire

//--- const_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module const_loader_top import flash_load_pkg::*; #(
  parameter logic [FLASH_AW-1:0] BASE_ADDR      = 23'h7FC000,
  parameter int                  NUM_CONST      = 34,
  parameter int                  ACCESS_CYCLES  = 3,
  parameter int                  TIMEOUT_CYCLES = 64
) (
  input  logic                CLK,
  input  logic                addr_rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [11:0]         paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output logic [FLASH_AW-1:0] flash_addr,
  output logic [FLASH_DW-1:0] flash_wdata,
  output logic                flash_ce_n,
  output logic                flash_we_n,
  output logic                flash_oe_n,
  input  logic [FLASH_DW-1:0] flash_rdata,
  input  logic                flash_ready,
  output logic                load_ena
);

  logic                load_start;
  logic                busy;
  logic                al_done;
  logic [FLASH_AW-1:0] al_addr;
  logic [FLASH_DW-1:0] al_cmd_data;
  logic [1:0]          al_op;
  logic                al_execute;
  logic                clr_al_done;
  logic                abort_op;
  logic [OFFS_W-1:0]   al_cnt;
  logic [ST_W-1:0]     al_status;
  logic [OFFS_W-1:0]   wr_idx;
  logic [FLASH_DW-1:0] rd_data;
  logic [OFFS_W-1:0]   const_rd_idx;
  logic [FLASH_DW-1:0] const_rd_data;

  apb_load_regs #(
    .NUM_CONST (NUM_CONST)
  ) u_apb_load_regs (
    .CLK           (CLK),
    .addr_rst      (addr_rst),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .al_status     (al_status),
    .al_cnt        (al_cnt),
    .load_ena      (load_ena),
    .const_rd_data (const_rd_data),
    .load_start    (load_start),
    .const_rd_idx  (const_rd_idx)
  );

  auto_load_const #(
    .BASE_ADDR      (BASE_ADDR),
    .NUM_CONST      (NUM_CONST),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_auto_load_const (
    .CLK         (CLK),
    .addr_rst    (addr_rst),
    .busy        (busy),
    .load_start  (load_start),
    .al_done     (al_done),
    .al_addr     (al_addr),
    .al_cmd_data (al_cmd_data),
    .al_op       (al_op),
    .al_execute  (al_execute),
    .load_ena    (load_ena),
    .clr_al_done (clr_al_done),
    .abort_op    (abort_op),
    .al_cnt      (al_cnt),
    .al_status   (al_status),
    .wr_idx      (wr_idx)
  );

  flash_cmd_ctrl #(
    .ACCESS_CYCLES (ACCESS_CYCLES)
  ) u_flash_cmd_ctrl (
    .CLK         (CLK),
    .addr_rst    (addr_rst),
    .execute     (al_execute),
    .op          (al_op),
    .addr        (al_addr),
    .cmd_data    (al_cmd_data),
    .clr_done    (clr_al_done),
    .abort_op    (abort_op),
    .flash_rdata (flash_rdata),
    .flash_ready (flash_ready),
    .busy        (busy),
    .done        (al_done),
    .rd_data     (rd_data),
    .flash_addr  (flash_addr),
    .flash_wdata (flash_wdata),
    .flash_ce_n  (flash_ce_n),
    .flash_we_n  (flash_we_n),
    .flash_oe_n  (flash_oe_n)
  );

  // Each word lands in storage as the sequencer clears done
  const_regfile #(
    .NUM_CONST (NUM_CONST)
  ) u_const_regfile (
    .CLK     (CLK),
    .wr_en   (clr_al_done),
    .wr_idx  (wr_idx),
    .wr_data (rd_data),
    .rd_idx  (const_rd_idx),
    .rd_data (const_rd_data)
  );

endmodule

`default_nettype wire

//--- apb_load_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_load_regs import flash_load_pkg::*; #(
  parameter int NUM_CONST = 34
) (
  input  logic                CLK,
  input  logic                addr_rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [11:0]         paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  input  logic [ST_W-1:0]     al_status,
  input  logic [OFFS_W-1:0]   al_cnt,
  input  logic                load_ena,
  input  logic [FLASH_DW-1:0] const_rd_data,
  output logic                load_start,
  output logic [OFFS_W-1:0]   const_rd_idx
);

  logic [11:0] win_off;
  logic        is_ctrl;
  logic        is_status;
  logic        is_const;
  logic        const_rd;
  logic        addr_err;
  logic        access;
  logic        wait_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  assign win_off   = paddr - REG_CONST_BASE;
  assign is_ctrl   = (paddr == REG_CTRL);
  assign is_status = (paddr == REG_STATUS);
  assign is_const  = (paddr >= REG_CONST_BASE) && (win_off[1:0] == 2'b00) &&
                     (win_off[11:2] < NUM_CONST);
  assign const_rd  = is_const && !pwrite;
  // Constant window is read-only
  assign addr_err  = !(is_ctrl || is_status || is_const) || (is_const && pwrite);

  assign const_rd_idx = win_off[OFFS_W+1:2];

  assign access  = psel && penable;
  assign pready  = access && (!const_rd || wait_q);
  assign pslverr = pready && addr_err;

  // One wait state covers the registered storage read
  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && const_rd && !wait_q;
    end
  end

  // Start ignored while a load is running
  assign load_start = access && pwrite && is_ctrl && pwdata[0] && !load_ena;

  // Status word holds status in [2:0], al_cnt in [13:8] and load_ena in [16]
  always_comb begin
    prdata = '0;
    if (is_ctrl) begin
      prdata[0] = load_ena;
    end else if (is_status) begin
      prdata[ST_W-1:0]       = al_status;
      prdata[8+OFFS_W-1:8]   = al_cnt;
      prdata[16]             = load_ena;
    end else if (is_const) begin
      prdata[FLASH_DW-1:0] = const_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- const_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module const_regfile import flash_load_pkg::*; #(
  parameter int NUM_CONST = 34
) (
  input  logic                CLK,
  input  logic                wr_en,
  input  logic [OFFS_W-1:0]   wr_idx,
  input  logic [FLASH_DW-1:0] wr_data,
  input  logic [OFFS_W-1:0]   rd_idx,
  output logic [FLASH_DW-1:0] rd_data
);

  logic [FLASH_DW-1:0] mem [NUM_CONST];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (wr_en && (wr_idx < NUM_CONST)) begin
      mem[wr_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered read port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    // Indices past the block read as zero
    if (rd_idx < NUM_CONST) begin
      rd_data <= mem[rd_idx];
    end else begin
      rd_data <= '0;
    end
  end

endmodule

`default_nettype wire

//--- flash_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flash_cmd_ctrl import flash_load_pkg::*; #(
  parameter int ACCESS_CYCLES = 3
) (
  input  logic                CLK,
  input  logic                addr_rst,
  input  logic                execute,
  input  logic [1:0]          op,
  input  logic [FLASH_AW-1:0] addr,
  input  logic [FLASH_DW-1:0] cmd_data,
  input  logic                clr_done,
  input  logic                abort_op,
  input  logic [FLASH_DW-1:0] flash_rdata,
  input  logic                flash_ready,
  output logic                busy,
  output logic                done,
  output logic [FLASH_DW-1:0] rd_data,
  output logic [FLASH_AW-1:0] flash_addr,
  output logic [FLASH_DW-1:0] flash_wdata,
  output logic                flash_ce_n,
  output logic                flash_we_n,
  output logic                flash_oe_n
);

  localparam int CW = $clog2(ACCESS_CYCLES + 1);

  ////////////////////////////////////////////////////////////
  // Bus phases
  ////////////////////////////////////////////////////////////
  localparam logic [2:0] PH_IDLE = 3'd0;
  localparam logic [2:0] PH_CMD  = 3'd1;   // WE strobe with command word
  localparam logic [2:0] PH_GAP  = 3'd2;   // write recovery before OE
  localparam logic [2:0] PH_WAIT = 3'd3;   // OE low while waiting for ready
  localparam logic [2:0] PH_HOLD = 3'd4;   // OE held for data access time

  logic [2:0]    phase;
  logic [2:0]    phase_nxt;
  logic [CW-1:0] cnt;
  logic [CW-1:0] cnt_nxt;
  logic          launch;
  logic          capture;

  assign launch  = (phase == PH_IDLE) && execute && (op != OP_NONE);
  assign capture = (phase == PH_HOLD) && (cnt == '0) && !abort_op;
  assign busy    = (phase != PH_IDLE);

  always_comb begin
    phase_nxt = phase;
    cnt_nxt   = cnt;
    case (phase)
      PH_IDLE: begin
        if (launch) begin
          phase_nxt = PH_CMD;
          cnt_nxt   = CW'(ACCESS_CYCLES - 1);
        end
      end
      PH_CMD: begin
        if (cnt == '0) phase_nxt = PH_GAP;
        else           cnt_nxt   = cnt - 1'b1;
      end
      PH_GAP: phase_nxt = PH_WAIT;
      PH_WAIT: begin
        if (flash_ready) begin
          phase_nxt = PH_HOLD;
          cnt_nxt   = CW'(ACCESS_CYCLES - 1);
        end
      end
      PH_HOLD: begin
        if (cnt == '0) phase_nxt = PH_IDLE;
        else           cnt_nxt   = cnt - 1'b1;
      end
      default: phase_nxt = PH_IDLE;
    endcase
    // Abort wins over everything
    if (abort_op) begin
      phase_nxt = PH_IDLE;
    end
  end

  // Strobes come straight from flops
  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      phase      <= PH_IDLE;
      cnt        <= '0;
      flash_ce_n <= 1'b1;
      flash_we_n <= 1'b1;
      flash_oe_n <= 1'b1;
    end else begin
      phase      <= phase_nxt;
      cnt        <= cnt_nxt;
      flash_ce_n <= (phase_nxt == PH_IDLE);
      flash_we_n <= (phase_nxt != PH_CMD);
      flash_oe_n <= !((phase_nxt == PH_WAIT) || (phase_nxt == PH_HOLD));
    end
  end

  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      done <= 1'b0;
    end else if (capture) begin
      done <= 1'b1;
    end else if (clr_done) begin
      done <= 1'b0;
    end
  end

  // Address, command and read data
  always_ff @(posedge CLK) begin
    if (launch) begin
      flash_addr  <= addr;
      flash_wdata <= cmd_data;
    end
    if (capture) begin
      rd_data <= flash_rdata;
    end
  end

endmodule

`default_nettype wire

//--- auto_load_const.sv
`timescale 1ns/1ps
`default_nettype none

module auto_load_const import flash_load_pkg::*; #(
  parameter logic [FLASH_AW-1:0] BASE_ADDR      = 23'h7FC000,
  parameter int                  NUM_CONST      = 34,
  parameter int                  TIMEOUT_CYCLES = 64
) (
  input  logic                CLK,
  input  logic                addr_rst,
  input  logic                busy,
  input  logic                load_start,
  input  logic                al_done,
  output logic [FLASH_AW-1:0] al_addr,
  output logic [FLASH_DW-1:0] al_cmd_data,
  output logic [1:0]          al_op,
  output logic                al_execute,
  output logic                load_ena,
  output logic                clr_al_done,
  output logic                abort_op,
  output logic [OFFS_W-1:0]   al_cnt,
  output logic [ST_W-1:0]     al_status,
  output logic [OFFS_W-1:0]   wr_idx
);

  logic [OFFS_W-1:0] offset;
  logic              rst_addr;
  logic              inc_addr;
  logic              completed;
  logic              aborted;

  // Offset fills the low bits of the 64-word aligned block
  assign al_addr     = {BASE_ADDR[FLASH_AW-1:OFFS_W], offset};
  assign al_cmd_data = READ_ARRAY_CMD;
  assign al_op       = OP_READ;
  assign wr_idx      = offset;

  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      offset <= '0;
    end else if (rst_addr) begin
      offset <= '0;
    end else if (inc_addr) begin
      offset <= offset + 1'b1;
    end
  end

  // Offset of the last word written to storage
  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      al_cnt <= '0;
    end else if (rst_addr) begin
      al_cnt <= '0;
    end else if (clr_al_done) begin
      al_cnt <= offset;
    end
  end

  // Sticky status bits cleared when a new load starts
  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      al_status <= '0;
    end else if (rst_addr) begin
      al_status <= '0;
    end else begin
      if (clr_al_done) al_status[ST_STORED] <= 1'b1;
      if (completed)   al_status[ST_COMPLETED] <= 1'b1;
      if (aborted)     al_status[ST_ABORTED] <= 1'b1;
    end
  end

  auto_load_fsm #(
    .MAX_ADDR       (OFFS_W'(NUM_CONST - 1)),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_auto_load_fsm (
    .CLK         (CLK),
    .addr_rst    (addr_rst),
    .start       (load_start),
    .busy        (busy),
    .al_done     (al_done),
    .addr        (offset),
    .execute     (al_execute),
    .inc         (inc_addr),
    .rst_addr    (rst_addr),
    .clr_al_done (clr_al_done),
    .completed   (completed),
    .aborted     (aborted),
    .al_ena      (load_ena),
    .abort_op    (abort_op)
  );

endmodule

`default_nettype wire

//--- auto_load_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module auto_load_fsm import flash_load_pkg::*; #(
  parameter logic [OFFS_W-1:0] MAX_ADDR       = 6'd33,
  parameter int                TIMEOUT_CYCLES = 64
) (
  input  logic              CLK,
  input  logic              addr_rst,
  input  logic              start,
  input  logic              busy,
  input  logic              al_done,
  input  logic [OFFS_W-1:0] addr,
  output logic              execute,
  output logic              inc,
  output logic              rst_addr,
  output logic              clr_al_done,
  output logic              completed,
  output logic              aborted,
  output logic              al_ena,
  output logic              abort_op
);

  localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_ISSUE   = 3'd1;
  localparam logic [2:0] S_WAIT    = 3'd2;
  localparam logic [2:0] S_STORE   = 3'd3;
  localparam logic [2:0] S_ADVANCE = 3'd4;
  localparam logic [2:0] S_FINISH  = 3'd5;

  logic [2:0]    state;
  logic [2:0]    state_nxt;
  logic [TW-1:0] tmo_cnt;
  logic          timeout;

  // Flash took too long to answer
  assign timeout = (state == S_WAIT) && !al_done &&
                   (tmo_cnt == TW'(TIMEOUT_CYCLES - 1));

  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Ready timeout counts only while waiting on the controller
  always_ff @(posedge CLK or posedge addr_rst) begin
    if (addr_rst) begin
      tmo_cnt <= '0;
    end else if (state == S_WAIT) begin
      tmo_cnt <= tmo_cnt + 1'b1;
    end else begin
      tmo_cnt <= '0;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_nxt = S_ISSUE;
        end
      end
      S_ISSUE:   state_nxt = S_WAIT;
      S_WAIT: begin
        if (al_done && !busy) begin
          state_nxt = S_STORE;
        end else if (timeout) begin
          state_nxt = S_IDLE;
        end
      end
      S_STORE:   state_nxt = S_ADVANCE;
      S_ADVANCE: state_nxt = (addr == MAX_ADDR) ? S_FINISH : S_ISSUE;
      S_FINISH:  state_nxt = S_IDLE;
      default:   state_nxt = S_IDLE;
    endcase
  end

  assign execute     = (state == S_ISSUE);
  assign rst_addr    = (state == S_IDLE) && start;
  assign clr_al_done = (state == S_STORE);
  assign inc         = (state == S_ADVANCE) && (addr != MAX_ADDR);
  assign completed   = (state == S_FINISH);
  assign aborted     = timeout;
  assign abort_op    = timeout;
  assign al_ena      = (state != S_IDLE);

endmodule

`default_nettype wire

//--- flash_load_pkg.sv
`default_nettype none

package flash_load_pkg;

  ////////////////////////////////////////////////////////////
  // Flash bus
  ////////////////////////////////////////////////////////////
  localparam int FLASH_AW = 23;
  localparam int FLASH_DW = 16;

  // Word offset inside the parameter block
  localparam int OFFS_W = 6;

  // Read Array command written before every read cycle
  localparam logic [FLASH_DW-1:0] READ_ARRAY_CMD = 16'h00FF;

  // Operation codes from the auto-load block
  localparam logic [1:0] OP_NONE = 2'b00;
  localparam logic [1:0] OP_READ = 2'b10;

  ////////////////////////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////////////////////////
  localparam logic [11:0] REG_CTRL       = 12'h000;
  localparam logic [11:0] REG_STATUS     = 12'h004;
  localparam logic [11:0] REG_CONST_BASE = 12'h100;

  // Sticky status bits
  localparam int ST_W         = 3;
  localparam int ST_STORED    = 0;
  localparam int ST_COMPLETED = 1;
  localparam int ST_ABORTED   = 2;

endpackage

`default_nettype wire
